// File: Bender.yml
package:
  name: ec_add

sources:
  - ec_pkg.sv
  - mod_mul.sv
  - mod_addsub.sv
  - ec_point_add.sv
  - ec_add_top.sv
  - target: simulation
    files:
      - tb_ec_add.sv

// File: ec_add_cases.txt
// kind p1_x p1_y p1_z p2_x p2_y p2_z x3 y3 z3 err, all hex 16-bit words, mod 65521
// kind 0 general, 1 p1 at infinity, 2 p2 at infinity, 3 equal x, 4 equal points, ffff ends
0000 0001 0002 0001 0003 0005 0001 ffea 0011 0002 0000
0001 0005 0006 0000 0007 0008 0009 0007 0008 0009 0000
0000 0002 0003 0002 0005 0007 0001 ef12 c028 0024 0000
0002 000a 000b 000c 0001 0002 0000 000a 000b 000c 0000
0003 0004 0005 0001 0004 0009 0001 0000 0000 0000 0000
0004 0004 0005 0001 0004 0005 0001 0000 0000 0000 0001
0000 fff0 0001 0001 0001 fff0 0003 0630 a638 001e 0000
0000 0003 0004 0002 0007 0009 0003 04d9 aa4c 0006 0000
0003 fff0 1234 0777 fff0 4321 0777 0000 0000 0000 0000
0002 1111 2222 3333 4444 5555 0000 1111 2222 3333 0000
0001 0000 0000 0000 abcd 00ef 0012 abcd 00ef 0012 0000
ffff 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000

// File: ec_add_top.sv
/*
  Top level of the point adder
  Scheduler plus one multiplier, one adder and one subtractor
*/
`default_nettype none

module ec_add_top import ec_pkg::*; #(
  parameter int              FE_W  = 16,
  parameter logic [FE_W-1:0] P_MOD = 65521
) (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic [FE_W-1:0] i_p1_x,
  input  logic [FE_W-1:0] i_p1_y,
  input  logic [FE_W-1:0] i_p1_z,
  input  logic [FE_W-1:0] i_p2_x,
  input  logic [FE_W-1:0] i_p2_y,
  input  logic [FE_W-1:0] i_p2_z,
  input  logic            i_val,
  output logic            o_rdy,
  output logic [FE_W-1:0] o_p_x,
  output logic [FE_W-1:0] o_p_y,
  output logic [FE_W-1:0] o_p_z,
  output logic            o_err,
  output logic            o_val,
  input  logic            i_rdy
);

  // Request and result streams per unit
  logic             mul_val, mul_rdy, mul_res_val, mul_res_rdy;
  logic [FE_W-1:0]  mul_a, mul_b, mul_res_dat;
  logic [TAG_W-1:0] mul_tag, mul_res_tag;
  logic             add_val, add_rdy, add_res_val, add_res_rdy;
  logic [FE_W-1:0]  add_a, add_b, add_res_dat;
  logic [TAG_W-1:0] add_tag, add_res_tag;
  logic             sub_val, sub_rdy, sub_res_val, sub_res_rdy;
  logic [FE_W-1:0]  sub_a, sub_b, sub_res_dat;
  logic [TAG_W-1:0] sub_tag, sub_res_tag;

  ec_point_add #(.FE_W(FE_W), .P_MOD(P_MOD)) u_point_add (
    .i_clk, .i_rst,
    .i_p1_x, .i_p1_y, .i_p1_z, .i_p2_x, .i_p2_y, .i_p2_z, .i_val, .o_rdy,
    .o_p_x, .o_p_y, .o_p_z, .o_val, .o_err, .i_rdy,
    .o_mul_val(mul_val), .o_mul_a(mul_a), .o_mul_b(mul_b), .o_mul_tag(mul_tag),
    .i_mul_rdy(mul_rdy), .i_mul_res_val(mul_res_val), .i_mul_res_dat(mul_res_dat),
    .i_mul_res_tag(mul_res_tag), .o_mul_res_rdy(mul_res_rdy),
    .o_add_val(add_val), .o_add_a(add_a), .o_add_b(add_b), .o_add_tag(add_tag),
    .i_add_rdy(add_rdy), .i_add_res_val(add_res_val), .i_add_res_dat(add_res_dat),
    .i_add_res_tag(add_res_tag), .o_add_res_rdy(add_res_rdy),
    .o_sub_val(sub_val), .o_sub_a(sub_a), .o_sub_b(sub_b), .o_sub_tag(sub_tag),
    .i_sub_rdy(sub_rdy), .i_sub_res_val(sub_res_val), .i_sub_res_dat(sub_res_dat),
    .i_sub_res_tag(sub_res_tag), .o_sub_res_rdy(sub_res_rdy)
  );

  // FE_W+1 clock product
  mod_mul #(.FE_W(FE_W), .P_MOD(P_MOD)) u_mul (
    .i_clk, .i_rst,
    .i_val(mul_val), .i_a(mul_a), .i_b(mul_b), .i_tag(mul_tag), .o_rdy(mul_rdy),
    .o_res_val(mul_res_val), .o_res_dat(mul_res_dat), .o_res_tag(mul_res_tag),
    .i_res_rdy(mul_res_rdy)
  );

  mod_addsub #(.FE_W(FE_W), .P_MOD(P_MOD), .SUBTRACT(1'b0)) u_add (
    .i_clk, .i_rst,
    .i_val(add_val), .i_a(add_a), .i_b(add_b), .i_tag(add_tag), .o_rdy(add_rdy),
    .o_res_val(add_res_val), .o_res_dat(add_res_dat), .o_res_tag(add_res_tag),
    .i_res_rdy(add_res_rdy)
  );

  mod_addsub #(.FE_W(FE_W), .P_MOD(P_MOD), .SUBTRACT(1'b1)) u_sub (
    .i_clk, .i_rst,
    .i_val(sub_val), .i_a(sub_a), .i_b(sub_b), .i_tag(sub_tag), .o_rdy(sub_rdy),
    .o_res_val(sub_res_val), .o_res_dat(sub_res_dat), .o_res_tag(sub_res_tag),
    .i_res_rdy(sub_res_rdy)
  );

endmodule

`default_nettype wire

// File: ec_pkg.sv
/*
  Shared definitions for the Jacobian point adder
  Equation tag width, equation count and scheduler state
*/
`default_nettype none

package ec_pkg;

  // Tag carried with every request, one code per equation
  localparam int TAG_W = 5;

  // Equations in the Jacobian addition sequence
  localparam int N_EQ = 24;

  // Scheduler state
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0, // Waiting for a point pair
    ST_RUN  = 2'd1, // Equations in flight
    ST_DONE = 2'd2  // Result held until taken
  } ec_state_e;

endpackage

`default_nettype wire

// File: ec_point_add.sv
/*
  Jacobian point adder, special case checks and equation scheduler
  Issued and done masks drive out-of-order issue to shared mul, add and sub units
  Latched points and temporaries A to D hold intermediate values
*/
`default_nettype none

module ec_point_add import ec_pkg::*; #(
  parameter int              FE_W  = 16,
  parameter logic [FE_W-1:0] P_MOD = 65521
) (
  input  logic             i_clk,
  input  logic             i_rst,
  // Input points
  input  logic [FE_W-1:0]  i_p1_x,
  input  logic [FE_W-1:0]  i_p1_y,
  input  logic [FE_W-1:0]  i_p1_z,
  input  logic [FE_W-1:0]  i_p2_x,
  input  logic [FE_W-1:0]  i_p2_y,
  input  logic [FE_W-1:0]  i_p2_z,
  input  logic             i_val,
  output logic             o_rdy,
  // Output point
  output logic [FE_W-1:0]  o_p_x,
  output logic [FE_W-1:0]  o_p_y,
  output logic [FE_W-1:0]  o_p_z,
  output logic             o_val,
  output logic             o_err,
  input  logic             i_rdy,
  // Multiplier
  output logic             o_mul_val,
  output logic [FE_W-1:0]  o_mul_a,
  output logic [FE_W-1:0]  o_mul_b,
  output logic [TAG_W-1:0] o_mul_tag,
  input  logic             i_mul_rdy,
  input  logic             i_mul_res_val,
  input  logic [FE_W-1:0]  i_mul_res_dat,
  input  logic [TAG_W-1:0] i_mul_res_tag,
  output logic             o_mul_res_rdy,
  // Adder
  output logic             o_add_val,
  output logic [FE_W-1:0]  o_add_a,
  output logic [FE_W-1:0]  o_add_b,
  output logic [TAG_W-1:0] o_add_tag,
  input  logic             i_add_rdy,
  input  logic             i_add_res_val,
  input  logic [FE_W-1:0]  i_add_res_dat,
  input  logic [TAG_W-1:0] i_add_res_tag,
  output logic             o_add_res_rdy,
  // Subtractor
  output logic             o_sub_val,
  output logic [FE_W-1:0]  o_sub_a,
  output logic [FE_W-1:0]  o_sub_b,
  output logic [TAG_W-1:0] o_sub_tag,
  input  logic             i_sub_rdy,
  input  logic             i_sub_res_val,
  input  logic [FE_W-1:0]  i_sub_res_dat,
  input  logic [TAG_W-1:0] i_sub_res_tag,
  output logic             o_sub_res_rdy
);

  // Which unit serves each equation, eq 15 is a plain copy
  localparam logic [N_EQ-1:0] MUL_EQS = 24'hD85CFF;
  localparam logic [N_EQ-1:0] ADD_EQS = 24'h010000;
  localparam logic [N_EQ-1:0] SUB_EQS = 24'h262300;
  localparam int              EQ_COPY = 15;

  ec_state_e        state;
  logic [N_EQ-1:0]  eq_issued, eq_done;
  logic [N_EQ-1:0]  eq_go;   // Predecessors done
  logic [N_EQ-1:0]  eq_cand; // Ready and not yet sent
  logic [FE_W-1:0]  p1_x, p1_y, p1_z, p2_x, p2_y, p2_z;
  logic [FE_W-1:0]  tmp_a, tmp_b, tmp_c, tmp_d;
  logic [2*FE_W-1:0] ops [N_EQ]; // {a, b} per equation
  logic             mul_hit, add_hit, sub_hit;
  logic [TAG_W-1:0] mul_sel, add_sel, sub_sel;
  logic             mul_fire, add_fire, sub_fire;
  logic             mul_ret, add_ret, sub_ret;
  logic             run, accept, bad_tag;

  // Lowest pending equation wins, gives {hit, index}
  function automatic logic [TAG_W:0] pick_first(input logic [N_EQ-1:0] cand);
    logic [TAG_W:0] r;
    r = '0;
    for (int i = N_EQ - 1; i >= 0; i--) begin
      if (cand[i]) r = {1'b1, TAG_W'(i)};
    end
    return r;
  endfunction

  function automatic logic tag_ok(input logic [TAG_W-1:0] tag, input logic [N_EQ-1:0] eqs);
    return (tag < TAG_W'(N_EQ)) && eqs[tag];
  endfunction

  // Dependency graph
  always_comb begin
    eq_go[0]  = 1'b1;                                // A = Z2*Z2
    eq_go[1]  = eq_done[0];                          // U1 = A*X1
    eq_go[2]  = 1'b1;                                // C = Z1*Z1
    eq_go[3]  = eq_done[2];                          // U2 = C*X2
    eq_go[4]  = eq_done[1];                          // A = A*Z2
    eq_go[5]  = eq_done[4];                          // S1 = A*Y1
    eq_go[6]  = eq_done[3];                          // C = C*Z1
    eq_go[7]  = eq_done[6];                          // S2 = C*Y2
    eq_go[8]  = eq_done[1] && eq_done[3];            // H = U2 - U1
    eq_go[9]  = eq_done[5] && eq_done[7];            // R = S2 - S1
    eq_go[10] = eq_done[9];                          // X3 = R^2
    eq_go[11] = eq_done[8];                          // D = H^2
    eq_go[12] = eq_done[8] && eq_done[11];           // H^3 into X2
    eq_go[13] = eq_done[10] && eq_done[12];          // X3 -= H^3
    eq_go[14] = eq_done[1] && eq_done[11];           // U1*H^2 into X1
    eq_go[15] = eq_done[14];                         // Y3 = U1*H^2
    eq_go[16] = eq_done[14] && eq_done[15];          // X1 doubled
    eq_go[17] = eq_done[13] && eq_done[16];          // X3 -= 2*U1*H^2
    eq_go[18] = eq_done[15] && eq_done[17];          // Y3 -= X3
    eq_go[19] = eq_done[9] && eq_done[18];           // Y3 *= R
    eq_go[20] = eq_done[5] && eq_done[12] && eq_done[13]; // S1*H^3, X2 read by 13 first
    eq_go[21] = eq_done[19] && eq_done[20];          // Y3 -= S1*H^3
    eq_go[22] = 1'b1;                                // Z3 = Z1*Z2
    eq_go[23] = eq_done[8] && eq_done[22];           // Z3 *= H
  end

  assign eq_cand = eq_go & ~eq_issued;

  // Operand pairs, same order as the graph above
  always_comb begin
    ops = '{default: '0};
    ops[0]  = {p2_z, p2_z};
    ops[1]  = {tmp_a, p1_x};
    ops[2]  = {p1_z, p1_z};
    ops[3]  = {tmp_c, p2_x};
    ops[4]  = {tmp_a, p2_z};
    ops[5]  = {tmp_a, p1_y};
    ops[6]  = {tmp_c, p1_z};
    ops[7]  = {tmp_c, p2_y};
    ops[8]  = {p2_x, p1_x};
    ops[9]  = {tmp_c, tmp_a};
    ops[10] = {p2_y, p2_y};
    ops[11] = {tmp_b, tmp_b};
    ops[12] = {tmp_d, tmp_b};
    ops[13] = {o_p_x, p2_x};
    ops[14] = {tmp_d, p1_x};
    ops[16] = {p1_x, p1_x};
    ops[17] = {o_p_x, p1_x};
    ops[18] = {o_p_y, o_p_x};
    ops[19] = {o_p_y, p2_y};
    ops[20] = {p2_x, tmp_a};
    ops[21] = {o_p_y, p2_x};
    ops[22] = {p1_z, p2_z};
    ops[23] = {o_p_z, tmp_b};
  end

  assign {mul_hit, mul_sel} = pick_first(eq_cand & MUL_EQS);
  assign {add_hit, add_sel} = pick_first(eq_cand & ADD_EQS);
  assign {sub_hit, sub_sel} = pick_first(eq_cand & SUB_EQS);

  assign run      = (state == ST_RUN);
  assign accept   = i_val && o_rdy;
  assign mul_fire = run && mul_hit && (!o_mul_val || i_mul_rdy); // Slot free or emptying
  assign add_fire = run && add_hit && (!o_add_val || i_add_rdy);
  assign sub_fire = run && sub_hit && (!o_sub_val || i_sub_rdy);
  assign mul_ret  = i_mul_res_val && o_mul_res_rdy;
  assign add_ret  = i_add_res_val && o_add_res_rdy;
  assign sub_ret  = i_sub_res_val && o_sub_res_rdy;
  assign bad_tag  = (mul_ret && !tag_ok(i_mul_res_tag, MUL_EQS))
                 || (add_ret && !tag_ok(i_add_res_tag, ADD_EQS))
                 || (sub_ret && !tag_ok(i_sub_res_tag, SUB_EQS));

  assign o_rdy         = (state == ST_IDLE);
  assign o_val         = (state == ST_DONE);
  assign o_mul_res_rdy = run;
  assign o_add_res_rdy = run;
  assign o_sub_res_rdy = run;

  // Control state and equation masks
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= ST_IDLE;
      o_err     <= 1'b0;
      eq_issued <= '0;
      eq_done   <= '0;
      o_mul_val <= 1'b0;
      o_add_val <= 1'b0;
      o_sub_val <= 1'b0;
    end else begin
      if (mul_fire) o_mul_val <= 1'b1;
      else if (i_mul_rdy) o_mul_val <= 1'b0;
      if (add_fire) o_add_val <= 1'b1;
      else if (i_add_rdy) o_add_val <= 1'b0;
      if (sub_fire) o_sub_val <= 1'b1;
      else if (i_sub_rdy) o_sub_val <= 1'b0;
      case (state)
        ST_IDLE: if (accept) begin
          eq_issued <= '0;
          eq_done   <= '0;
          // Point at infinity, opposite points or doubling finish at once
          if (i_p1_z == '0 || i_p2_z == '0 || i_p1_x == i_p2_x) state <= ST_DONE;
          else state <= ST_RUN;
          o_err <= (i_p1_z != '0) && (i_p2_z != '0) && (i_p1_x == i_p2_x)
                && (i_p1_y == i_p2_y);
        end
        ST_RUN: begin
          if (mul_fire) eq_issued[mul_sel] <= 1'b1;
          if (add_fire) eq_issued[add_sel] <= 1'b1;
          if (sub_fire) eq_issued[sub_sel] <= 1'b1;
          if (eq_cand[EQ_COPY]) begin
            eq_issued[EQ_COPY] <= 1'b1;
            eq_done[EQ_COPY]   <= 1'b1;
          end
          if (mul_ret) eq_done[i_mul_res_tag] <= 1'b1;
          if (add_ret) eq_done[i_add_res_tag] <= 1'b1;
          if (sub_ret) eq_done[i_sub_res_tag] <= 1'b1;
          if (bad_tag) begin
            o_err <= 1'b1;
            state <= ST_DONE;
          end else if (&eq_done) begin
            state <= ST_DONE;
          end
        end
        ST_DONE: if (i_rdy) begin
          state <= ST_IDLE;
          o_err <= 1'b0;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Latched points, temporaries, output point and request payloads
  always_ff @(posedge i_clk) begin
    if (accept) begin
      p1_x <= i_p1_x;
      p1_y <= i_p1_y;
      p1_z <= i_p1_z;
      p2_x <= i_p2_x;
      p2_y <= i_p2_y;
      p2_z <= i_p2_z;
      if (i_p1_z == '0) begin // P1 at infinity
        o_p_x <= i_p2_x;
        o_p_y <= i_p2_y;
        o_p_z <= i_p2_z;
      end else if (i_p2_z == '0) begin
        o_p_x <= i_p1_x;
        o_p_y <= i_p1_y;
        o_p_z <= i_p1_z;
      end else begin // Zero point, overwritten in the general case
        o_p_x <= '0;
        o_p_y <= '0;
        o_p_z <= '0;
      end
    end
    if (mul_fire) begin
      {o_mul_a, o_mul_b} <= ops[mul_sel];
      o_mul_tag <= mul_sel;
    end
    if (add_fire) begin
      {o_add_a, o_add_b} <= ops[add_sel];
      o_add_tag <= add_sel;
    end
    if (sub_fire) begin
      {o_sub_a, o_sub_b} <= ops[sub_sel];
      o_sub_tag <= sub_sel;
    end
    if (run && eq_cand[EQ_COPY]) o_p_y <= p1_x;
    if (mul_ret) begin
      case (i_mul_res_tag)
        5'd0, 5'd4, 5'd5: tmp_a <= i_mul_res_dat;
        5'd1, 5'd14:      p1_x  <= i_mul_res_dat;
        5'd2, 5'd6, 5'd7: tmp_c <= i_mul_res_dat;
        5'd3, 5'd12, 5'd20: p2_x <= i_mul_res_dat;
        5'd10:            o_p_x <= i_mul_res_dat;
        5'd11:            tmp_d <= i_mul_res_dat;
        5'd19:            o_p_y <= i_mul_res_dat;
        5'd22, 5'd23:     o_p_z <= i_mul_res_dat;
        default: ;
      endcase
    end
    if (add_ret && i_add_res_tag == 5'd16) p1_x <= i_add_res_dat; // 2*U1*H^2
    if (sub_ret) begin
      case (i_sub_res_tag)
        5'd8:         tmp_b <= i_sub_res_dat; // H
        5'd9:         p2_y  <= i_sub_res_dat; // R
        5'd13, 5'd17: o_p_x <= i_sub_res_dat;
        5'd18, 5'd21: o_p_y <= i_sub_res_dat;
        default: ;
      endcase
    end
  end

  // Every returning tag must belong to an equation already sent out
  assert property (@(posedge i_clk) disable iff (i_rst)
    (!mul_ret || eq_issued[i_mul_res_tag]) && (!add_ret || eq_issued[i_add_res_tag])
    && (!sub_ret || eq_issued[i_sub_res_tag]));

  // Held result does not move under back-pressure
  assert property (@(posedge i_clk) disable iff (i_rst)
    (o_val && !i_rdy) |=> o_val && $stable({o_p_x, o_p_y, o_p_z, o_err}));

  // Reduced field elements reach the output
  assert property (@(posedge i_clk) disable iff (i_rst)
    o_val |-> (o_p_x < P_MOD) && (o_p_y < P_MOD) && (o_p_z < P_MOD));

endmodule

`default_nettype wire

// File: mod_addsub.sv
/*
  Modular adder or subtractor, chosen by SUBTRACT
  One registered stage, tag returned with the result
*/
`default_nettype none

module mod_addsub import ec_pkg::*; #(
  parameter int              FE_W     = 16,
  parameter logic [FE_W-1:0] P_MOD    = 65521,
  parameter bit              SUBTRACT = 1'b0
) (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_val,
  input  logic [FE_W-1:0]  i_a,
  input  logic [FE_W-1:0]  i_b,
  input  logic [TAG_W-1:0] i_tag,
  output logic             o_rdy,
  output logic             o_res_val,
  output logic [FE_W-1:0]  o_res_dat,
  output logic [TAG_W-1:0] o_res_tag,
  input  logic             i_res_rdy
);

  localparam logic [FE_W:0] P_EXT = {1'b0, P_MOD};

  logic [FE_W:0]   raw;  // One spare bit for carry or borrow
  logic [FE_W:0]   fix;
  logic [FE_W-1:0] res;

  always_comb begin
    if (SUBTRACT) begin
      raw = {1'b0, i_a} - {1'b0, i_b};
      fix = raw + P_EXT;
      res = raw[FE_W] ? fix[FE_W-1:0] : raw[FE_W-1:0]; // Borrow wraps back up
    end else begin
      raw = {1'b0, i_a} + {1'b0, i_b};
      fix = raw - P_EXT;
      res = (raw >= P_EXT) ? fix[FE_W-1:0] : raw[FE_W-1:0];
    end
  end

  // Streams one result per clock when the sink keeps up
  assign o_rdy = !o_res_val || i_res_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_res_val <= 1'b0;
    end else if (o_rdy) begin
      o_res_val <= i_val;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_val && o_rdy) begin
      o_res_dat <= res;
      o_res_tag <= i_tag;
    end
  end

  assert property (@(posedge i_clk) disable iff (i_rst) o_res_val |-> (o_res_dat < P_MOD));

endmodule

`default_nettype wire

// File: mod_mul.sv
/*
  Modular multiplier, interleaved double-and-add over the bits of b
  One bit per clock from the top, reduced mod P_MOD every step
  Request and result are valid/ready streams, tag returned with the product
*/
`default_nettype none

module mod_mul import ec_pkg::*; #(
  parameter int              FE_W  = 16,
  parameter logic [FE_W-1:0] P_MOD = 65521
) (
  input  logic             i_clk,
  input  logic             i_rst,
  // Request stream
  input  logic             i_val,
  input  logic [FE_W-1:0]  i_a,
  input  logic [FE_W-1:0]  i_b,
  input  logic [TAG_W-1:0] i_tag,
  output logic             o_rdy,
  // Result stream
  output logic             o_res_val,
  output logic [FE_W-1:0]  o_res_dat,
  output logic [TAG_W-1:0] o_res_tag,
  input  logic             i_res_rdy
);

  localparam int CNT_W = $clog2(FE_W + 1);
  localparam logic [FE_W:0] P_EXT = {1'b0, P_MOD};

  logic             busy;
  logic [CNT_W-1:0] step_cnt; // Steps taken so far
  logic [FE_W-1:0]  a_r;
  logic [FE_W-1:0]  b_r;      // Shifts left, top bit is the current one
  logic [FE_W-1:0]  acc;
  logic [TAG_W-1:0] tag_r;
  logic [FE_W:0]    dbl;
  logic [FE_W:0]    sum;
  logic             stepping;

  assign stepping = busy && (step_cnt != CNT_W'(FE_W));

  // acc*2 mod P, then plus a when the bit is set, mod P
  always_comb begin
    dbl = {acc, 1'b0};
    if (dbl >= P_EXT) dbl = dbl - P_EXT;
    sum = dbl + (b_r[FE_W-1] ? {1'b0, a_r} : '0); // Both terms below P
    if (sum >= P_EXT) sum = sum - P_EXT;
  end

  // Control
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy      <= 1'b0;
      step_cnt  <= '0;
      o_res_val <= 1'b0;
    end else if (o_res_val) begin
      if (i_res_rdy) o_res_val <= 1'b0; // Free again next clock
    end else if (busy) begin
      if (stepping) begin
        step_cnt <= step_cnt + 1'b1;
      end else begin
        busy      <= 1'b0;
        o_res_val <= 1'b1; // FE_W+1 clocks after accept
      end
    end else if (i_val) begin
      busy     <= 1'b1;
      step_cnt <= '0;
    end
  end

  // Operands and running product
  always_ff @(posedge i_clk) begin
    if (i_val && o_rdy) begin
      a_r   <= i_a;
      b_r   <= i_b;
      acc   <= '0;
      tag_r <= i_tag;
    end else if (stepping) begin
      acc <= sum[FE_W-1:0];
      b_r <= b_r << 1;
    end
  end

  assign o_rdy     = !busy && !o_res_val; // Only one product at a time
  assign o_res_dat = acc;
  assign o_res_tag = tag_r;

  // Operands must already be reduced
  assert property (@(posedge i_clk) disable iff (i_rst)
    (i_val && o_rdy) |-> (i_a < P_MOD) && (i_b < P_MOD));

endmodule

`default_nettype wire

// File: sim.f
ec_pkg.sv
mod_mul.sv
mod_addsub.sv
ec_point_add.sv
ec_add_top.sv
tb_ec_add.sv

// File: tb_ec_add.sv
/*
  Testbench for the Jacobian point adder
  Cases from ec_add_cases.txt, random output back-pressure
  Result, latency and handshake checks on the top level
*/
`default_nettype none

module tb_ec_add;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int              FE_W      = 16;
  localparam logic [FE_W-1:0] P_MOD     = 16'd65521;
  localparam int              MAX_CASES = 32;
  localparam int              CASE_W    = 11;                   // Words per case line
  localparam int              CASE_CLKS = 24 * (FE_W + 2) + 100; // Worst case per addition

  logic            i_clk;
  logic            i_rst;
  logic [FE_W-1:0] i_p1_x, i_p1_y, i_p1_z;
  logic [FE_W-1:0] i_p2_x, i_p2_y, i_p2_z;
  logic            i_val;
  logic            o_rdy;
  logic [FE_W-1:0] o_p_x, o_p_y, o_p_z;
  logic            o_err;
  logic            o_val;
  logic            i_rdy;

  logic [15:0]     case_mem [MAX_CASES*CASE_W]; // kind, p1, p2, expected point, err
  int              n_cases;
  bit              loaded;
  int              cur_case;                    // Case on the input port
  int              errors, checks, results;
  int              pend_q [$];                  // Accepted and output not yet taken
  int              cyc, acc_cyc;
  bit              in_flight, seen_val, hold_prev;
  logic [FE_W-1:0] hold_x, hold_y, hold_z;
  logic            hold_err;
  integer          seed = 78495;
  logic [31:0]     rnd;

  ec_add_top #(.FE_W(FE_W), .P_MOD(P_MOD)) i_dut (
    .i_clk, .i_rst,
    .i_p1_x, .i_p1_y, .i_p1_z, .i_p2_x, .i_p2_y, .i_p2_z,
    .i_val, .o_rdy,
    .o_p_x, .o_p_y, .o_p_z, .o_err, .o_val, .i_rdy
  );

  always #2 i_clk = ~i_clk; // 4 ns period

  // Random back-pressure on the output stream
  always @(posedge i_clk) begin
    rnd = $random(seed);
    if (i_rst) i_rdy <= 1'b0;
    else i_rdy <= (rnd[1:0] != 2'b00); // Ready about three clocks in four
  end

  function automatic logic [15:0] case_word(input int k, input int w);
    return case_mem[k*CASE_W + w];
  endfunction

  task automatic compare_word(input string name, input logic [FE_W-1:0] exp,
                              input logic [FE_W-1:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic note_error(input string msg);
    errors++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  // Expected point and flag of case k against the DUT output
  task automatic check_result(input int k);
    compare_word($sformatf("case %0d o_err", k), case_word(k, 10), FE_W'(o_err));
    if (case_word(k, 10) == 16'h0) begin // Point undefined when doubling is refused
      compare_word($sformatf("case %0d o_p_x", k), case_word(k, 7), o_p_x);
      compare_word($sformatf("case %0d o_p_y", k), case_word(k, 8), o_p_y);
      compare_word($sformatf("case %0d o_p_z", k), case_word(k, 9), o_p_z);
    end
  endtask

  // Called just after a rising edge
  task automatic drive_case(input int k);
    cur_case = k;
    i_p1_x <= case_word(k, 1);
    i_p1_y <= case_word(k, 2);
    i_p1_z <= case_word(k, 3);
    i_p2_x <= case_word(k, 4);
    i_p2_y <= case_word(k, 5);
    i_p2_z <= case_word(k, 6);
    i_val  <= 1'b1;
  endtask

  // Returns on the rising edge that takes the offered case
  task automatic wait_accept();
    @(negedge i_clk);
    while (!o_rdy) @(negedge i_clk);
    @(posedge i_clk);
  endtask

  // Output side sampled mid-cycle where every DUT output is settled
  always @(negedge i_clk) begin : monitor
    cyc++;
    if (!i_rst) begin
      if (hold_prev) begin // Held under back-pressure
        if (!o_val) note_error("o_val dropped before the output transfer");
        compare_word("o_p_x held", hold_x, o_p_x);
        compare_word("o_p_y held", hold_y, o_p_y);
        compare_word("o_p_z held", hold_z, o_p_z);
        compare_word("o_err held", FE_W'(hold_err), FE_W'(o_err));
      end
      compare_word("o_rdy", FE_W'(!in_flight), FE_W'(o_rdy)); // Low while busy
      if (o_val && !seen_val) begin
        seen_val = 1'b1;
        if (!in_flight) begin
          note_error("o_val raised with no case accepted");
        end else if (case_word(pend_q[0], 0) != 16'h0 && cyc != acc_cyc + 1) begin
          note_error($sformatf("special case %0d took %0d clocks to o_val",
                               pend_q[0], cyc - acc_cyc));
        end
      end
      if (o_val && i_rdy) begin // Output transfer on the next edge
        if (pend_q.size() == 0) note_error("output transfer with no case accepted");
        else check_result(pend_q.pop_front());
        results++;
        in_flight = 1'b0;
        seen_val  = 1'b0;
      end
      hold_prev = o_val && !i_rdy;
      hold_x    = o_p_x;
      hold_y    = o_p_y;
      hold_z    = o_p_z;
      hold_err  = o_err;
      if (i_val && o_rdy) begin // Input transfer on the next edge
        pend_q.push_back(cur_case);
        acc_cyc   = cyc;
        in_flight = 1'b1;
      end
    end
  end

  // Limit from the case count, plus reset and idle tail
  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = ((n_cases > 0) ? n_cases : 1) * CASE_CLKS + 40;
    repeat (limit) @(posedge i_clk);
    $display("Timeout: the adder did not return all results within %0d clocks", limit);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    int k;
    i_clk  = 1'b0;
    i_rst  = 1'b1;
    i_val  = 1'b0;
    i_rdy  = 1'b0;
    i_p1_x = '0;
    i_p1_y = '0;
    i_p1_z = '0;
    i_p2_x = '0;
    i_p2_y = '0;
    i_p2_z = '0;
    $readmemh("ec_add_cases.txt", case_mem);
    n_cases = 0;
    while (n_cases < MAX_CASES && case_word(n_cases, 0) !== 16'hffff
           && !$isunknown(case_word(n_cases, 0))) begin
      n_cases++;
    end
    if (n_cases == 0) note_error("no cases found in ec_add_cases.txt");
    loaded = 1'b1;

    repeat (2) @(posedge i_clk);
    i_rst <= 1'b0;
    @(negedge i_clk);
    compare_word("o_val after reset", '0, FE_W'(o_val));
    compare_word("o_err after reset", '0, FE_W'(o_err));

    // Next case goes out at once and waits on o_rdy
    @(posedge i_clk);
    for (k = 0; k < n_cases; k++) begin
      drive_case(k);
      wait_accept();
    end
    i_val <= 1'b0;

    wait (results == n_cases);
    repeat (20) @(posedge i_clk); // Idle tail to catch stray outputs
    if (results != n_cases) begin
      note_error($sformatf("%0d results for %0d cases", results, n_cases));
    end

    $display("Errors: %0d, checks: %0d, cases: %0d, results: %0d",
             errors, checks, n_cases, results);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
